// File: hdl/crypto_defines.svh
`ifndef CRYPTO_DEFINES_SVH
`define CRYPTO_DEFINES_SVH

// custom-0 major opcode that carries the bit-manipulation group
`define CRY_OPCODE 7'b0001011

// funct3 operation codes
`define CRY_HMDST  3'd0
`define CRY_CNTP   3'd1
`define CRY_PKG    3'd2
`define CRY_RVRS   3'd3
`define CRY_SLADD  3'd4
`define CRY_CNTZ   3'd5

// architectural register count, x0 included
`define CRY_NUM_REGS 32

`endif

// File: hdl/crypto_pkg.sv
`include "crypto_defines.svh"

package crypto_pkg;

   // data word for operands, results and register contents
   typedef logic [31:0] word_t;

   typedef logic [$clog2(`CRY_NUM_REGS)-1:0] reg_addr_t;

   // operation select, taken straight from funct3
   typedef logic [2:0] cry_op_t;

   typedef enum logic {
      IDLE,
      BUSY
   } issue_state_t;

endpackage

// File: hdl/crypto_op_if.sv
`timescale 1ns/1ps

interface crypto_op_if;
   import crypto_pkg::*;

   // issue side, held constant while active is high
   logic    active;
   cry_op_t op;
   word_t   rs1_val;
   word_t   rs2_val;

   // unit side, result and ready registered and stall combinational
   word_t   result;
   logic    ready;
   logic    stall;

   modport issuer (
      output active,
      output op,
      output rs1_val,
      output rs2_val,
      input  result,
      input  ready,
      input  stall
   );

   modport unit (
      input  active,
      input  op,
      input  rs1_val,
      input  rs2_val,
      output result,
      output ready,
      output stall
   );

endinterface

// File: hdl/crypto_issue.sv
`timescale 1ns/1ps
`include "crypto_defines.svh"

module crypto_issue (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  instr_valid_i,
   input  logic [31:0]           instr_i,
   input  logic                  freeze_i,
   input  crypto_pkg::word_t     rs1_data_i,
   input  crypto_pkg::word_t     rs2_data_i,
   output crypto_pkg::reg_addr_t rs1_addr_o,
   output crypto_pkg::reg_addr_t rs2_addr_o,
   output logic                  wb_en_o,
   output crypto_pkg::reg_addr_t wb_addr_o,
   output crypto_pkg::word_t     wb_data_o,
   output logic                  busy_o,
   output logic                  result_valid_o,
   output crypto_pkg::word_t     result_o,
   output crypto_pkg::reg_addr_t result_rd_o,
   output logic                  illegal_o,
   crypto_op_if.issuer           op
);
   import crypto_pkg::*;

   issue_state_t state_q;
   logic         illegal_q;
   cry_op_t      op_q;
   reg_addr_t    rd_q;
   word_t        rs1_q;
   word_t        rs2_q;
   logic         legal;
   logic         try_issue;
   logic         accept;
   logic         done;

   // only funct3 codes up to the trailing-zero count are defined
   assign legal = (instr_i[6:0] == `CRY_OPCODE) && (instr_i[31:25] == 7'd0) &&
                  (instr_i[14:12] <= `CRY_CNTZ);

   assign try_issue = instr_valid_i && (state_q == IDLE) && !freeze_i;
   assign accept    = try_issue && legal;
   assign done      = (state_q == BUSY) && op.ready && !freeze_i;

   // operands are looked up combinationally and captured on accept
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= IDLE;
         illegal_q <= 1'b0;
      end else begin
         illegal_q <= try_issue && !legal;
         case (state_q)
            IDLE: if (accept) state_q <= BUSY;
            BUSY: if (done) state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         op_q  <= instr_i[14:12];
         rd_q  <= instr_i[11:7];
         rs1_q <= rs1_data_i;
         rs2_q <= rs2_data_i;
      end
   end

   // leaving BUSY drops active, which clears the unit at the next edge
   assign op.active  = (state_q == BUSY);
   assign op.op      = op_q;
   assign op.rs1_val = rs1_q;
   assign op.rs2_val = rs2_q;

   assign wb_en_o        = done;
   assign wb_addr_o      = rd_q;
   assign wb_data_o      = op.result;
   assign busy_o         = (state_q == BUSY);
   assign result_valid_o = done;
   assign result_o       = op.result;
   assign result_rd_o    = rd_q;
   assign illegal_o      = illegal_q;

endmodule

// File: hdl/crypto_regfile.sv
`timescale 1ns/1ps
`include "crypto_defines.svh"

module crypto_regfile (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  crypto_pkg::reg_addr_t rs1_addr_i,
   input  crypto_pkg::reg_addr_t rs2_addr_i,
   input  logic                  wb_en_i,
   input  crypto_pkg::reg_addr_t wb_addr_i,
   input  crypto_pkg::word_t     wb_data_i,
   input  logic                  load_en_i,
   input  crypto_pkg::reg_addr_t load_addr_i,
   input  crypto_pkg::word_t     load_data_i,
   output crypto_pkg::word_t     rs1_data_o,
   output crypto_pkg::word_t     rs2_data_o
);
   import crypto_pkg::*;

   word_t regs_q [`CRY_NUM_REGS];

   // writeback takes the port when both sides write in one cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `CRY_NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wb_en_i && (wb_addr_i != '0)) begin
         regs_q[wb_addr_i] <= wb_data_i;
      end else if (load_en_i && (load_addr_i != '0)) begin
         regs_q[load_addr_i] <= load_data_i;
      end
   end

   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: hdl/crypto_unit.sv
`timescale 1ns/1ps
`include "crypto_defines.svh"

module crypto_unit (
   input logic       clk_i,
   input logic       rst_n_i,
   input logic       freeze_i,
   crypto_op_if.unit op
);
   import crypto_pkg::*;

   logic  phase_q;
   logic  phase_d;
   logic  ready_q;
   logic  ready_d;
   word_t result_q;
   word_t result_d;
   logic  stall_c;
   word_t cnt_src;
   word_t grp3;
   word_t grp6;

   // halving search, each step strips a run of zeros half the previous width
   function automatic word_t trailing_zeros(word_t v);
      word_t x;
      word_t n;
      x = v;
      n = '0;
      if (v == '0) begin
         n = 32'd32;
      end else begin
         for (int w = 16; w >= 1; w = w / 2) begin
            if ((x & ((32'd1 << w) - 32'd1)) == '0) begin
               n = n + word_t'(w);
               x = x >> w;
            end
         end
      end
      return n;
   endfunction

   // both bit counts share one adder tree, hamming distance counts the xor
   assign cnt_src = (op.op == `CRY_HMDST) ? (op.rs1_val ^ op.rs2_val) : op.rs1_val;

   // per-group bit counts in 3-bit fields, then folded into 6-bit fields
   assign grp3 = cnt_src - ((cnt_src >> 1) & 32'hdb6d_b6db) - ((cnt_src >> 2) & 32'h4924_9249);
   assign grp6 = (grp3 + (grp3 >> 3)) & 32'hc71c_71c7;

   always_comb begin
      result_d = result_q;
      ready_d  = ready_q;
      phase_d  = phase_q;
      stall_c  = 1'b0;
      if (op.active && !freeze_i) begin
         case (op.op)
            `CRY_HMDST, `CRY_CNTP: begin
               if (!phase_q) begin
                  result_d = grp6;
                  ready_d  = 1'b0;
                  phase_d  = 1'b1;
                  stall_c  = 1'b1;
               end else begin
                  // 64 is 1 mod 63, so this sums the 6-bit fields
                  result_d = result_q % 32'd63;
                  ready_d  = 1'b1;
                  phase_d  = 1'b0;
               end
            end
            `CRY_PKG: begin
               result_d = {op.rs2_val[15:0], op.rs1_val[15:0]};
               ready_d  = 1'b1;
            end
            `CRY_RVRS: begin
               result_d = {op.rs1_val[7:0], op.rs1_val[15:8],
                           op.rs1_val[23:16], op.rs1_val[31:24]};
               ready_d  = 1'b1;
            end
            `CRY_SLADD: begin
               result_d = (op.rs1_val << 1) + op.rs2_val;
               ready_d  = 1'b1;
            end
            `CRY_CNTZ: begin
               result_d = trailing_zeros(op.rs1_val);
               ready_d  = 1'b1;
            end
            default: begin
               result_d = result_q;
            end
         endcase
      end
   end

   // a low active wipes the unit so the next instruction starts in phase 0
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !op.active) begin
         phase_q  <= 1'b0;
         ready_q  <= 1'b0;
         result_q <= '0;
      end else begin
         phase_q  <= phase_d;
         ready_q  <= ready_d;
         result_q <= result_d;
      end
   end

   assign op.result = result_q;
   assign op.ready  = ready_q;
   assign op.stall  = stall_c;

endmodule

// File: hdl/crypto_exec_top.sv
`timescale 1ns/1ps

module crypto_exec_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  instr_valid_i,
   input  logic [31:0]           instr_i,
   input  logic                  freeze_i,
   input  logic                  load_en_i,
   input  crypto_pkg::reg_addr_t load_addr_i,
   input  crypto_pkg::word_t     load_data_i,
   output logic                  busy_o,
   output logic                  result_valid_o,
   output crypto_pkg::word_t     result_o,
   output crypto_pkg::reg_addr_t result_rd_o,
   output logic                  illegal_o
);
   import crypto_pkg::*;

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     rs1_data;
   word_t     rs2_data;
   logic      wb_en;
   reg_addr_t wb_addr;
   word_t     wb_data;

   crypto_op_if op_if ();

   crypto_issue u_issue (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .instr_valid_i  (instr_valid_i),
      .instr_i        (instr_i),
      .freeze_i       (freeze_i),
      .rs1_data_i     (rs1_data),
      .rs2_data_i     (rs2_data),
      .rs1_addr_o     (rs1_addr),
      .rs2_addr_o     (rs2_addr),
      .wb_en_o        (wb_en),
      .wb_addr_o      (wb_addr),
      .wb_data_o      (wb_data),
      .busy_o         (busy_o),
      .result_valid_o (result_valid_o),
      .result_o       (result_o),
      .result_rd_o    (result_rd_o),
      .illegal_o      (illegal_o),
      .op             (op_if.issuer)
   );

   crypto_regfile u_regfile (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .wb_en_i     (wb_en),
      .wb_addr_i   (wb_addr),
      .wb_data_i   (wb_data),
      .load_en_i   (load_en_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .rs1_data_o  (rs1_data),
      .rs2_data_o  (rs2_data)
   );

   crypto_unit u_unit (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .freeze_i (freeze_i),
      .op       (op_if.unit)
   );

endmodule

// File: sim/crypto_exec_assertions.sv
`timescale 1ns/1ps
`include "crypto_defines.svh"

module crypto_exec_assertions (
   input logic                clk_i,
   input logic                rst_n_i,
   input logic                busy_i,
   input logic                result_valid_i,
   input logic                illegal_i,
   input logic                active_i,
   input crypto_pkg::cry_op_t op_i,
   input crypto_pkg::word_t   rs1_i,
   input crypto_pkg::word_t   rs2_i,
   input logic                stall_i
);

   // busy only drops at the edge that ends a result cycle
   busy_release: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(busy_i) |-> $past(result_valid_i))
      else $error("busy fell without a result in the previous cycle");

   result_or_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(result_valid_i && illegal_i))
      else $error("result valid and illegal are high together");

   // the unit recomputes every cycle, so its inputs must not move while active
   operands_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (active_i && $past(active_i)) |-> ($stable(op_i) && $stable(rs1_i) && $stable(rs2_i)))
      else $error("operands changed while the unit was active");

   stall_on_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stall_i |-> ((op_i == `CRY_HMDST) || (op_i == `CRY_CNTP)))
      else $error("stall raised for an operation that is not a bit count");

endmodule

// File: sim/tb_crypto_exec.sv
`timescale 1ns/1ps
`include "crypto_defines.svh"

module tb_crypto_exec;
   import crypto_pkg::*;

   localparam int HALF_PERIOD = 20;
   localparam int NUM_PATS = 28;
   localparam int NUM_RAND = 12;
   localparam int FREEZE_CYCLES = 3;
   localparam int RESULT_WAIT = 20;
   // each test takes at most 20 cycles, the extra tests are the directed ones
   localparam int WATCHDOG_CYCLES = (NUM_PATS + NUM_RAND + 8) * 20 + 200;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        instr_valid;
   logic [31:0] instr;
   logic        freeze;
   logic        load_en;
   reg_addr_t   load_addr;
   word_t       load_data;
   logic        busy;
   logic        result_valid;
   word_t       result;
   reg_addr_t   result_rd;
   logic        illegal;

   word_t  pat_mem [0:4*NUM_PATS-1];
   int     err_cnt = 0;
   int     test_err0 = 0;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     rv_cnt = 0;
   int     ill_cnt = 0;
   int     cycle_cnt = 0;
   int     issue_cycle = 0;
   integer seed;

   crypto_exec_top dut0 (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .instr_valid_i  (instr_valid),
      .instr_i        (instr),
      .freeze_i       (freeze),
      .load_en_i      (load_en),
      .load_addr_i    (load_addr),
      .load_data_i    (load_data),
      .busy_o         (busy),
      .result_valid_o (result_valid),
      .result_o       (result),
      .result_rd_o    (result_rd),
      .illegal_o      (illegal)
   );

   bind crypto_issue crypto_exec_assertions u_assertions (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .busy_i         (busy_o),
      .result_valid_i (result_valid_o),
      .illegal_i      (illegal_o),
      .active_i       (op.active),
      .op_i           (op.op),
      .rs1_i          (op.rs1_val),
      .rs2_i          (op.rs2_val),
      .stall_i        (op.stall)
   );

   always #HALF_PERIOD clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // outputs are counted mid-cycle, where they are settled
   always @(negedge clk) begin
      if (result_valid) rv_cnt++;
      if (illegal) ill_cnt++;
   end

   initial begin
      #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic word_t ref_popcount(word_t v);
      word_t n;
      n = '0;
      for (int i = 0; i < 32; i++) begin
         n = n + word_t'(v[i]);
      end
      return n;
   endfunction

   // the lowest set bit is the last one found, zero keeps 32
   function automatic word_t ref_ctz(word_t v);
      word_t n;
      n = 32'd32;
      for (int i = 31; i >= 0; i--) begin
         if (v[i]) n = word_t'(i);
      end
      return n;
   endfunction

   function automatic word_t expected_result(cry_op_t f3, word_t a, word_t b);
      case (f3)
         `CRY_HMDST: return ref_popcount(a ^ b);
         `CRY_CNTP:  return ref_popcount(a);
         `CRY_PKG:   return {b[15:0], a[15:0]};
         `CRY_RVRS:  return {a[7:0], a[15:8], a[23:16], a[31:24]};
         `CRY_SLADD: return (a << 1) + b;
         default:    return ref_ctz(a);
      endcase
   endfunction

   function automatic logic [31:0] make_instr(logic [6:0] funct7, reg_addr_t rs2,
                                              reg_addr_t rs1, cry_op_t f3,
                                              reg_addr_t rd, logic [6:0] opcode);
      return {funct7, rs2, rs1, f3, rd, opcode};
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic load_reg(input reg_addr_t addr, input word_t data);
      load_en = 1'b1;
      load_addr = addr;
      load_data = data;
      step();
      load_en = 1'b0;
   endtask

   task automatic issue_instr(input logic [31:0] word);
      instr_valid = 1'b1;
      instr = word;
      step();
      instr_valid = 1'b0;
      issue_cycle = cycle_cnt;
   endtask

   task automatic wait_result(output word_t res, output reg_addr_t rd, output int lat);
      int waited;
      waited = 0;
      res = '0;
      rd = '0;
      lat = -1;
      while (waited < RESULT_WAIT) begin
         @(negedge clk);
         if (result_valid) begin
            res = result;
            rd = result_rd;
            lat = cycle_cnt - issue_cycle;
            break;
         end
         waited++;
      end
      if (lat < 0) begin
         $display("no result_valid_o within %0d cycles at time %0t", RESULT_WAIT, $time);
         err_cnt++;
      end
      step();
   endtask

   task automatic run_op(input cry_op_t f3, input word_t a, input word_t b,
                         input word_t exp, input logic frz);
      word_t     res;
      reg_addr_t rd;
      int        lat;
      int        rv0;
      int        exp_lat;
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      rv0 = rv_cnt;
      exp_lat = ((f3 == `CRY_HMDST) || (f3 == `CRY_CNTP)) ? 2 : 1;
      issue_instr(make_instr(7'd0, 5'd2, 5'd1, f3, 5'd3, `CRY_OPCODE));
      if (frz) begin
         // freeze after the first unit cycle so a held phase or a held ready is covered
         step();
         freeze = 1'b1;
         repeat (FREEZE_CYCLES) step();
         freeze = 1'b0;
         exp_lat = exp_lat + FREEZE_CYCLES;
      end
      wait_result(res, rd, lat);
      check_value("result_o", res, exp);
      check_value("result_rd_o", 32'(rd), 32'd3);
      check_value("latency", 32'(lat), 32'(exp_lat));
      check_value("result_valid_o pulses", 32'(rv_cnt - rv0), 32'd1);
   endtask

   task automatic check_illegal(input logic [31:0] word);
      int   ill0;
      int   rv0;
      logic busy_seen;
      ill0 = ill_cnt;
      rv0 = rv_cnt;
      busy_seen = 1'b0;
      issue_instr(word);
      repeat (3) begin
         @(negedge clk);
         busy_seen = busy_seen | busy;
      end
      step();
      check_value("illegal_o pulses", 32'(ill_cnt - ill0), 32'd1);
      check_value("result_valid_o pulses", 32'(rv_cnt - rv0), 32'd0);
      check_value("busy_o", 32'(busy_seen), 32'd0);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt == test_err0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed", tests_run, name);
      end
      test_err0 = err_cnt;
   endtask

   initial begin
      word_t     res;
      reg_addr_t rd;
      int        lat;
      int        rv0;
      word_t     a;
      word_t     b;
      word_t     first;
      cry_op_t   f3;
      rst_n = 1'b0;
      instr_valid = 1'b0;
      instr = '0;
      freeze = 1'b0;
      load_en = 1'b0;
      load_addr = '0;
      load_data = '0;
      $readmemh("sim/crypto_patterns.mem", pat_mem);
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;

      @(negedge clk);
      check_value("busy_o", 32'(busy), 32'd0);
      check_value("result_valid_o", 32'(result_valid), 32'd0);
      check_value("illegal_o", 32'(illegal), 32'd0);
      step();
      // a cleared register has 32 trailing zeros
      issue_instr(make_instr(7'd0, 5'd0, 5'd17, `CRY_CNTZ, 5'd3, `CRY_OPCODE));
      wait_result(res, rd, lat);
      check_value("result_o", res, 32'd32);
      end_test("reset state");

      for (int p = 0; p < NUM_PATS; p++) begin
         run_op(pat_mem[4*p][2:0], pat_mem[4*p+1], pat_mem[4*p+2], pat_mem[4*p+3],
                pat_mem[4*p][4]);
         end_test($sformatf("pattern %0d", p));
      end

      a = 32'h0f0f_00f3;
      b = 32'h0000_1234;
      first = expected_result(`CRY_CNTP, a, b);
      run_op(`CRY_CNTP, a, b, first, 1'b0);
      issue_instr(make_instr(7'd0, 5'd2, 5'd3, `CRY_SLADD, 5'd5, `CRY_OPCODE));
      wait_result(res, rd, lat);
      check_value("result_o", res, expected_result(`CRY_SLADD, first, b));
      check_value("result_rd_o", 32'(rd), 32'd5);
      end_test("writeback reuse");

      load_reg(5'd0, 32'hdead_beef);
      issue_instr(make_instr(7'd0, 5'd2, 5'd1, `CRY_RVRS, 5'd0, `CRY_OPCODE));
      wait_result(res, rd, lat);
      check_value("result_rd_o", 32'(rd), 32'd0);
      issue_instr(make_instr(7'd0, 5'd1, 5'd0, `CRY_PKG, 5'd4, `CRY_OPCODE));
      wait_result(res, rd, lat);
      check_value("result_o", res, expected_result(`CRY_PKG, 32'd0, a));
      end_test("x0 stays zero");

      check_illegal(make_instr(7'd0, 5'd2, 5'd1, 3'd6, 5'd3, `CRY_OPCODE));
      check_illegal(make_instr(7'd0, 5'd2, 5'd1, 3'd7, 5'd3, `CRY_OPCODE));
      check_illegal(make_instr(7'd1, 5'd2, 5'd1, `CRY_HMDST, 5'd3, `CRY_OPCODE));
      check_illegal(make_instr(7'd0, 5'd2, 5'd1, `CRY_HMDST, 5'd3, 7'b0110011));
      end_test("illegal encodings");

      load_reg(5'd1, 32'h00ff_0f01);
      load_reg(5'd2, 32'h1357_9bdf);
      rv0 = rv_cnt;
      issue_instr(make_instr(7'd0, 5'd2, 5'd1, `CRY_HMDST, 5'd3, `CRY_OPCODE));
      // second request arrives while the bit count is still running
      instr_valid = 1'b1;
      instr = make_instr(7'd0, 5'd2, 5'd1, `CRY_PKG, 5'd6, `CRY_OPCODE);
      step();
      step();
      instr_valid = 1'b0;
      wait_result(res, rd, lat);
      check_value("result_o", res,
                  expected_result(`CRY_HMDST, 32'h00ff_0f01, 32'h1357_9bdf));
      check_value("result_rd_o", 32'(rd), 32'd3);
      repeat (3) step();
      check_value("result_valid_o pulses", 32'(rv_cnt - rv0), 32'd1);
      check_value("busy_o", 32'(busy), 32'd0);
      end_test("busy ignores new instruction");

      seed = 32'h6f7f;
      for (int i = 0; i < NUM_RAND; i++) begin
         a = $random(seed);
         b = $random(seed);
         f3 = cry_op_t'(i % 6);
         run_op(f3, a, b, expected_result(f3, a, b), 1'b0);
         end_test($sformatf("random %0d", i));
      end

      $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
               tests_run, tests_run - tests_failed, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim/crypto_patterns.mem
// columns: funct3 in bits 2:0 with freeze flag in bit 4, operand 1, operand 2, expected
// operand 1 goes to x1, operand 2 to x2, the result is written to x3
00000000 00000000 00000000 00000000
00000000 ffffffff 00000000 00000020
00000000 ffffffff ffffffff 00000000
00000000 12345678 87654321 0000000e
00000000 0f0f0f0f 00ff00ff 00000010
00000001 00000000 00000000 00000000
00000001 ffffffff 00000000 00000020
00000001 80000001 00000000 00000002
00000001 deadbeef 00000000 00000018
00000001 7fffffff 00000000 0000001f
00000002 12345678 9abcdef0 def05678
00000002 ffff0000 0000ffff ffff0000
00000002 00000000 0000a5a5 a5a50000
00000003 12345678 00000000 78563412
00000003 000000ff 00000000 ff000000
00000004 00000001 00000002 00000004
00000004 ffffffff 00000001 ffffffff
00000004 80000000 00000005 00000005
00000005 00000000 00000000 00000020
00000005 00000001 00000000 00000000
00000005 80000000 00000000 0000001f
00000005 00010000 00000000 00000010
00000005 00000008 00000000 00000003
00000011 f0f0f0f0 00000000 00000010
00000010 aaaaaaaa 55555555 00000020
00000014 40000000 00000003 80000003
00000013 a1b2c3d4 00000000 d4c3b2a1
00000015 00400000 00000000 00000016

// File: sources.f
+incdir+hdl
hdl/crypto_pkg.sv
hdl/crypto_op_if.sv
hdl/crypto_issue.sv
hdl/crypto_regfile.sv
hdl/crypto_unit.sv
hdl/crypto_exec_top.sv
sim/crypto_exec_assertions.sv
sim/tb_crypto_exec.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_crypto_exec \
   -f sources.f -o tb_crypto_exec_sim

./obj_dir/tb_crypto_exec_sim > sim.log 2>&1 || true
cat sim.log
grep -q '^RESULT: PASS$' sim.log
